// File: hw/dbg_pkg.sv
package dbg_pkg;

    // command codes carry the ascii value of the command letter
    typedef enum logic [7:0] {
        CMD_NONE = 8'h00,
        CMD_D    = 8'h44
    } cmd_e;

    // memory dump sequencer states
    typedef enum logic [2:0] {
        INIT      = 3'h0,
        SCAN      = 3'h1,
        PRINT_INF = 3'h2,
        PRINT_MAO = 3'h3,
        PRINTA    = 3'h4,
        DATA      = 3'h5,
        PRINTD    = 3'h6,
        FINISH    = 3'h7
    } dump_state_e;

    // parsed address from the host command line
    typedef struct packed {
        logic [31:0] addr;
        logic        no_addr;
    } rx_addr_t;

    // print request towards the transmit formatter
    typedef struct packed {
        logic        is_word;
        logic [31:0] data;
    } tx_req_t;

endpackage

// File: hw/data_mem.sv
`timescale 1ns/1ns

module data_mem #(
    parameter int MEM_AW = 8
) (
    input  logic              clk,
    input  logic              load_en,
    input  logic [MEM_AW-1:0] load_addr,
    input  logic [31:0]       load_data,
    input  logic [31:0]       raddr,
    output logic [31:0]       rdata
);

    localparam int DEPTH = 2 ** MEM_AW;

    logic [31:0] mem [DEPTH];

    // host side preload
    always_ff @(posedge clk) begin
        if (load_en)
            mem[load_addr] <= load_data;
    end

    // word address wraps at the array size
    assign rdata = mem[raddr[MEM_AW-1:0]];

endmodule

// File: hw/dbg_rx_parser.sv
`timescale 1ns/1ns

module dbg_rx_parser (
    input  logic              clk,
    input  logic              rstn,
    input  logic              rx_valid,
    input  logic [7:0]        rx_char,
    input  logic              req_rx,
    input  logic              finish,
    output dbg_pkg::cmd_e     sel_mode,
    output logic              sel_active,
    output logic              ack_rx,
    output dbg_pkg::rx_addr_t rx_addr
);

    typedef enum logic [1:0] {
        P_IDLE,
        P_COLLECT,
        P_HOLD,
        P_WAIT
    } parse_state_e;

    parse_state_e state;
    logic [31:0]  acc;
    logic         got_digit;
    logic [7:0]   char_uc;
    logic         is_hex;
    logic [3:0]   hex_val;

    // fold lower case letters onto upper case
    assign char_uc = (rx_char >= 8'h61 && rx_char <= 8'h7a) ? rx_char - 8'h20 : rx_char;

    always_comb begin
        is_hex  = 1'b1;
        hex_val = 4'h0;
        if (char_uc >= 8'h30 && char_uc <= 8'h39)
            hex_val = char_uc[3:0];
        else if (char_uc >= 8'h41 && char_uc <= 8'h46)
            hex_val = char_uc[3:0] + 4'd9;
        else
            is_hex = 1'b0;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= P_IDLE;
            sel_mode  <= dbg_pkg::CMD_NONE;
            ack_rx    <= 1'b0;
            acc       <= '0;
            got_digit <= 1'b0;
        end else begin
            ack_rx <= 1'b0;
            if (finish) begin
                state    <= P_IDLE;
                sel_mode <= dbg_pkg::CMD_NONE;
            end else begin
                case (state)
                    P_IDLE: begin
                        // only the dump letter opens a command
                        if (rx_valid && char_uc == dbg_pkg::CMD_D) begin
                            sel_mode  <= dbg_pkg::CMD_D;
                            acc       <= '0;
                            got_digit <= 1'b0;
                            state     <= P_COLLECT;
                        end
                    end
                    P_COLLECT: begin
                        if (rx_valid) begin
                            if (rx_char == 8'h0d) begin
                                if (req_rx) begin
                                    ack_rx <= 1'b1;
                                    state  <= P_WAIT;
                                end else begin
                                    state <= P_HOLD;
                                end
                            end else if (is_hex) begin
                                acc       <= {acc[27:0], hex_val};
                                got_digit <= 1'b1;
                            end
                            // spaces and stray characters fall through
                        end
                    end
                    P_HOLD: begin
                        // line complete, dump unit not asking yet
                        if (req_rx) begin
                            ack_rx <= 1'b1;
                            state  <= P_WAIT;
                        end
                    end
                    default: begin
                        // delivered, wait for finish
                        state <= P_WAIT;
                    end
                endcase
            end
        end
    end

    assign sel_active      = (sel_mode != dbg_pkg::CMD_NONE);
    assign rx_addr.addr    = acc;
    assign rx_addr.no_addr = ~got_digit;

endmodule

// File: hw/dbg_dump_unit.sv
`timescale 1ns/1ns

module dbg_dump_unit #(
    parameter int DUMP_WORDS = 8
) (
    input  logic              clk,
    input  logic              rstn,
    input  dbg_pkg::cmd_e     sel_mode,
    output logic              req_rx,
    input  logic              ack_rx,
    input  dbg_pkg::rx_addr_t rx_addr,
    output logic              finish,
    output logic [31:0]       addr_d,
    input  logic [31:0]       mem_rdata,
    output logic              req_tx,
    output dbg_pkg::tx_req_t  tx_req,
    input  logic              ack_tx
);

    localparam int CW = (DUMP_WORDS > 1) ? $clog2(DUMP_WORDS) : 1;

    localparam logic [31:0] CH_D     = 32'h44;
    localparam logic [31:0] CH_DASH  = 32'h2d;
    localparam logic [31:0] CH_COLON = 32'h3a;
    localparam logic [31:0] CH_CR    = 32'h0d;
    localparam logic [31:0] CH_LF    = 32'h0a;

    dbg_pkg::dump_state_e state;
    dbg_pkg::dump_state_e next_state;

    logic [31:0]   cur_addr;
    logic [31:0]   last_addr;
    logic          count_info;
    logic          count_finish;
    logic [CW-1:0] count_data;
    logic          active;

    assign active = (sel_mode == dbg_pkg::CMD_D);
    assign addr_d = cur_addr;

    // next state and the print request of each state
    always_comb begin
        next_state     = state;
        tx_req.is_word = 1'b0;
        tx_req.data    = '0;
        case (state)
            dbg_pkg::INIT: begin
                // hold off while the previous finish is still seen
                if (!finish)
                    next_state = dbg_pkg::SCAN;
            end
            dbg_pkg::SCAN: begin
                if (ack_rx)
                    next_state = dbg_pkg::PRINT_INF;
            end
            dbg_pkg::PRINT_INF: begin
                tx_req.data = count_info ? CH_DASH : CH_D;
                if (ack_tx && count_info)
                    next_state = dbg_pkg::PRINTA;
            end
            dbg_pkg::PRINTA: begin
                tx_req.is_word = 1'b1;
                tx_req.data    = cur_addr;
                if (ack_tx)
                    next_state = dbg_pkg::PRINT_MAO;
            end
            dbg_pkg::PRINT_MAO: begin
                tx_req.data = CH_COLON;
                if (ack_tx)
                    next_state = dbg_pkg::DATA;
            end
            dbg_pkg::DATA: begin
                next_state = dbg_pkg::PRINTD;
            end
            dbg_pkg::PRINTD: begin
                tx_req.is_word = 1'b1;
                tx_req.data    = mem_rdata;
                // counter wraps to zero after the last word
                if (ack_tx)
                    next_state = (count_data != '0) ? dbg_pkg::DATA : dbg_pkg::FINISH;
            end
            dbg_pkg::FINISH: begin
                tx_req.data = count_finish ? CH_LF : CH_CR;
                if (ack_tx && count_finish)
                    next_state = dbg_pkg::INIT;
            end
            default: begin
                next_state = dbg_pkg::INIT;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state        <= dbg_pkg::INIT;
            req_rx       <= 1'b0;
            req_tx       <= 1'b0;
            finish       <= 1'b0;
            count_info   <= 1'b0;
            count_finish <= 1'b0;
            count_data   <= '0;
            cur_addr     <= '0;
            last_addr    <= '0;
        end else if (!active) begin
            // command dropped, abandon whatever was in flight
            state        <= dbg_pkg::INIT;
            req_rx       <= 1'b0;
            req_tx       <= 1'b0;
            finish       <= 1'b0;
            count_info   <= 1'b0;
            count_finish <= 1'b0;
            count_data   <= '0;
        end else begin
            state <= next_state;
            case (state)
                dbg_pkg::INIT: begin
                    finish       <= 1'b0;
                    req_rx       <= 1'b0;
                    req_tx       <= 1'b0;
                    count_info   <= 1'b0;
                    count_finish <= 1'b0;
                    count_data   <= '0;
                end
                dbg_pkg::SCAN: begin
                    if (ack_rx) begin
                        req_rx   <= 1'b0;
                        cur_addr <= rx_addr.no_addr ? last_addr : rx_addr.addr;
                    end else begin
                        req_rx <= 1'b1;
                    end
                end
                dbg_pkg::PRINT_INF: begin
                    req_tx <= !ack_tx;
                    if (ack_tx)
                        count_info <= !count_info;
                end
                dbg_pkg::DATA: begin
                    // first word sits at the start address
                    count_data <= count_data + 1'b1;
                    if (count_data != '0)
                        cur_addr <= cur_addr + 32'd1;
                end
                dbg_pkg::FINISH: begin
                    last_addr <= cur_addr;
                    req_tx    <= !ack_tx;
                    if (ack_tx) begin
                        count_finish <= !count_finish;
                        if (count_finish)
                            finish <= 1'b1;
                    end
                end
                default: begin
                    // PRINTA, PRINT_MAO and PRINTD
                    req_tx <= !ack_tx;
                end
            endcase
        end
    end

endmodule

// File: hw/dbg_tx_formatter.sv
`timescale 1ns/1ns

module dbg_tx_formatter (
    input  logic             clk,
    input  logic             rstn,
    input  logic             req_tx,
    input  dbg_pkg::tx_req_t tx_req,
    output logic             ack_tx,
    output logic             tx_valid,
    output logic [7:0]       tx_char,
    input  logic             tx_ready
);

    typedef enum logic [1:0] {
        F_IDLE,
        F_SEND,
        F_REST
    } fmt_state_e;

    fmt_state_e  state;
    logic [31:0] shift_q;
    logic        is_word_q;
    logic [2:0]  nib_cnt;
    logic [3:0]  nib;
    logic        last_char;

    // top nibble is the next digit, msb first
    assign nib       = shift_q[31:28];
    assign last_char = !is_word_q || (nib_cnt == 3'd7);

    assign tx_valid = (state == F_SEND);
    // pulse with the last accepted character of the request
    assign ack_tx   = (state == F_SEND) && tx_ready && last_char;

    always_comb begin
        if (!is_word_q)
            tx_char = shift_q[7:0];
        else if (nib < 4'd10)
            tx_char = 8'h30 + {4'h0, nib};
        else
            tx_char = 8'h37 + {4'h0, nib};
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= F_IDLE;
            shift_q   <= '0;
            is_word_q <= 1'b0;
            nib_cnt   <= '0;
        end else begin
            case (state)
                F_IDLE: begin
                    if (req_tx) begin
                        shift_q   <= tx_req.data;
                        is_word_q <= tx_req.is_word;
                        nib_cnt   <= '0;
                        state     <= F_SEND;
                    end
                end
                F_SEND: begin
                    // character holds until the host takes it
                    if (tx_ready) begin
                        if (last_char) begin
                            state <= F_REST;
                        end else begin
                            shift_q <= {shift_q[27:0], 4'h0};
                            nib_cnt <= nib_cnt + 3'd1;
                        end
                    end
                end
                default: begin
                    // request is being withdrawn this cycle
                    state <= F_IDLE;
                end
            endcase
        end
    end

endmodule

// File: hw/dbg_console_top.sv
`timescale 1ns/1ns

module dbg_console_top #(
    parameter int DUMP_WORDS = 8,
    parameter int MEM_AW     = 8
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              rx_valid,
    input  logic [7:0]        rx_char,
    output logic              tx_valid,
    output logic [7:0]        tx_char,
    input  logic              tx_ready,
    input  logic              load_en,
    input  logic [MEM_AW-1:0] load_addr,
    input  logic [31:0]       load_data,
    output logic              busy
);

    dbg_pkg::cmd_e     sel_mode;
    dbg_pkg::rx_addr_t rx_addr;
    dbg_pkg::tx_req_t  tx_req;
    logic              req_rx;
    logic              ack_rx;
    logic              finish;
    logic              req_tx;
    logic              ack_tx;
    logic [31:0]       addr_d;
    logic [31:0]       mem_rdata;

    // busy follows the active command mode
    dbg_rx_parser u_parser (
        .clk        (clk),
        .rstn       (rstn),
        .rx_valid   (rx_valid),
        .rx_char    (rx_char),
        .req_rx     (req_rx),
        .finish     (finish),
        .sel_mode   (sel_mode),
        .sel_active (busy),
        .ack_rx     (ack_rx),
        .rx_addr    (rx_addr)
    );

    dbg_dump_unit #(
        .DUMP_WORDS (DUMP_WORDS)
    ) u_dump (
        .clk       (clk),
        .rstn      (rstn),
        .sel_mode  (sel_mode),
        .req_rx    (req_rx),
        .ack_rx    (ack_rx),
        .rx_addr   (rx_addr),
        .finish    (finish),
        .addr_d    (addr_d),
        .mem_rdata (mem_rdata),
        .req_tx    (req_tx),
        .tx_req    (tx_req),
        .ack_tx    (ack_tx)
    );

    dbg_tx_formatter u_fmt (
        .clk      (clk),
        .rstn     (rstn),
        .req_tx   (req_tx),
        .tx_req   (tx_req),
        .ack_tx   (ack_tx),
        .tx_valid (tx_valid),
        .tx_char  (tx_char),
        .tx_ready (tx_ready)
    );

    data_mem #(
        .MEM_AW (MEM_AW)
    ) u_mem (
        .clk       (clk),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .raddr     (addr_d),
        .rdata     (mem_rdata)
    );

endmodule

// File: tb/tb_dbg_console.sv
`timescale 1ns/1ns

module tb_dbg_console;

    localparam int DUMP_WORDS = 8;
    localparam int MEM_AW     = 8;
    localparam int NUM_TESTS  = 5;
    localparam int DONE_LIMIT = 400 * 4;
    localparam longint WATCHDOG_NS = NUM_TESTS * 400 * 40 * 4 + 50000;

    logic              clk = 1'b0;
    logic              rstn;
    logic              rx_valid;
    logic [7:0]        rx_char;
    logic              tx_valid;
    logic [7:0]        tx_char;
    logic              tx_ready = 1'b1;
    logic              load_en;
    logic [MEM_AW-1:0] load_addr;
    logic [31:0]       load_data;
    logic              busy;

    logic [31:0]  mem_copy [2**MEM_AW];
    byte unsigned captured[$];
    byte unsigned exp_q[$];
    bit           bp_en = 1'b0;
    int           errors = 0;
    int           mark = 0;
    int           passed = 0;
    int           failed = 0;

    dbg_console_top #(
        .DUMP_WORDS (DUMP_WORDS),
        .MEM_AW     (MEM_AW)
    ) dut_i (
        .clk       (clk),
        .rstn      (rstn),
        .rx_valid  (rx_valid),
        .rx_char   (rx_char),
        .tx_valid  (tx_valid),
        .tx_char   (tx_char),
        .tx_ready  (tx_ready),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .busy      (busy)
    );

    always #20 clk = ~clk;

    // host back-pressure, random only when enabled
    always @(negedge clk) begin
        tx_ready <= bp_en ? (($urandom % 2) == 0) : 1'b1;
    end

    // every accepted character
    always @(posedge clk) begin
        if (rstn && tx_valid && tx_ready)
            captured.push_back(tx_char);
    end

    assert property (@(posedge clk) disable iff (!rstn)
        (tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_char)))
    else begin
        errors++;
        $display("tx_char changed or tx_valid dropped while the host held tx_ready low");
    end

    assert property (@(posedge clk) !rstn |=> (!tx_valid && !busy))
    else begin
        errors++;
        $display("tx_valid or busy was high right after reset");
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all tests completed");
        $display("Test FAILED");
        $finish;
    end

    function automatic byte unsigned hex_char(input logic [3:0] nib);
        return (nib < 4'd10) ? 8'h30 + 8'(nib) : 8'h41 + 8'(nib) - 8'd10;
    endfunction

    task automatic push_word(input logic [31:0] w);
        int k;
        for (k = 7; k >= 0; k--)
            exp_q.push_back(hex_char(w[k*4 +: 4]));
    endtask

    // D- address : words CR LF
    task automatic build_expected(input logic [31:0] start);
        logic [31:0] a;
        int          i;
        exp_q.delete();
        exp_q.push_back(8'h44);
        exp_q.push_back(8'h2d);
        push_word(start);
        exp_q.push_back(8'h3a);
        for (i = 0; i < DUMP_WORDS; i++) begin
            a = start + 32'(i);
            push_word(mem_copy[a[MEM_AW-1:0]]);
        end
        exp_q.push_back(8'h0d);
        exp_q.push_back(8'h0a);
    endtask

    task automatic send_char(input byte unsigned c);
        @(negedge clk);
        rx_valid = 1'b1;
        rx_char  = c;
        @(negedge clk);
        rx_valid = 1'b0;
    endtask

    // command body then CR
    task automatic send_cmd(input string body);
        int i;
        for (i = 0; i < body.len(); i++)
            send_char(body[i]);
        send_char(8'h0d);
    endtask

    task automatic apply_reset;
        rstn = 1'b0;
        repeat (8) @(negedge clk);
        rstn = 1'b1;
    endtask

    task automatic wait_idle(input string name);
        int n;
        n = 0;
        while (busy && n < DONE_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            errors++;
            $display("%s: busy never fell, the dump did not complete", name);
        end
    endtask

    task automatic check_output(input string name);
        int i;
        int n;
        bit mism;
        mism = 1'b0;
        assert (captured.size() == exp_q.size()) else begin
            errors++;
            $display("CHECK FAILED %s: length expected %0d actual %0d",
                     name, exp_q.size(), captured.size());
        end
        n = (captured.size() < exp_q.size()) ? captured.size() : exp_q.size();
        for (i = 0; i < n && !mism; i++) begin
            assert (captured[i] == exp_q[i]) else begin
                errors++;
                mism = 1'b1;
                $display("CHECK FAILED %s: char %0d expected %02h actual %02h",
                         name, i, exp_q[i], captured[i]);
            end
        end
    endtask

    task automatic run_dump(input string name, input string cmd, input logic [31:0] start);
        captured.delete();
        build_expected(start);
        send_cmd(cmd);
        wait_idle(name);
        check_output(name);
    endtask

    task automatic end_test(input string name);
        if (errors == mark) begin
            passed++;
            $display("test %s passed", name);
        end else begin
            failed++;
            $display("test %s failed with %0d errors", name, errors - mark);
        end
        mark = errors;
    endtask

    initial begin
        logic [31:0] a3;
        logic [31:0] w;
        int          i;
        void'($urandom(84));
        rstn      = 1'b0;
        rx_valid  = 1'b0;
        rx_char   = 8'h00;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        apply_reset();

        // preload memory with random words
        for (i = 0; i < 2**MEM_AW; i++) begin
            w = $urandom;
            mem_copy[i] = w;
            @(negedge clk);
            load_en   = 1'b1;
            load_addr = MEM_AW'(i);
            load_data = w;
        end
        @(negedge clk);
        load_en = 1'b0;

        run_dump("explicit_addr", "D 00000010", 32'h10);
        end_test("explicit_addr");

        run_dump("resume", "D", 32'h17);
        end_test("resume");

        a3    = $urandom % 256;
        bp_en = 1'b1;
        run_dump("backpressure", $sformatf("D %h", a3), a3);
        bp_en = 1'b0;
        end_test("backpressure");

        // unknown letter leaves the console idle
        captured.delete();
        send_cmd("X 12");
        repeat (40) @(negedge clk);
        assert (captured.size() == 0 && !busy) else begin
            errors++;
            $display("CHECK FAILED unknown_cmd: chars expected 0 actual %0d, busy %0b",
                     captured.size(), busy);
        end
        run_dump("unknown_cmd", "d 3", 32'h3);
        end_test("unknown_cmd");

        apply_reset();
        run_dump("reset_wrap", "D", 32'h0);
        run_dump("reset_wrap", "D FC", 32'hfc);
        end_test("reset_wrap");

        $display("tests %0d passed %0d failed %0d errors %0d",
                 passed + failed, passed, failed, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// File: src.f
hw/dbg_pkg.sv
hw/data_mem.sv
hw/dbg_rx_parser.sv
hw/dbg_dump_unit.sv
hw/dbg_tx_formatter.sv
hw/dbg_console_top.sv
tb/tb_dbg_console.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_dbg_console -f src.f -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1
